//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_morra
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=

FAIL_MSG := TEST RESULT: FAIL
PASS_MSG := TEST RESULT: PASS
BIN      := $(BUILD_DIR)/$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/morra_pkg.sv
package morra_pkg;

    // Field widths
    localparam int MOVE_W  = 2;
    localparam int COUNT_W = 5;    // Holds up to MIN_ROUNDS + 15 + 1

    typedef logic [MOVE_W-1:0] move_t;
    typedef logic [1:0]        result_t;

    // Player 1 round wins minus player 2 round wins
    typedef logic signed [2:0] lead_t;

    // Move codes
    localparam move_t MOVE_NONE     = 2'b00;
    localparam move_t MOVE_ROCK     = 2'b01;
    localparam move_t MOVE_PAPER    = 2'b10;
    localparam move_t MOVE_SCISSORS = 2'b11;

    // Round and game results share one encoding
    localparam result_t RES_NONE = 2'b00;
    localparam result_t RES_P1   = 2'b01;
    localparam result_t RES_P2   = 2'b10;
    localparam result_t RES_DRAW = 2'b11;

    // Base of the round limit, also the early-finish threshold
    localparam logic [COUNT_W-1:0] MIN_ROUNDS = 5'd4;

    localparam lead_t LEAD_WIN   = 3'sd3;    // Ends the game at once
    localparam lead_t LEAD_EARLY = 3'sd2;    // Ends it once MIN_ROUNDS are done

    // The move inputs seen as a pair during play,
    // or as one limit offset in the start cycle
    typedef union packed {
        move_t [1:0]         moves;     // [1] player 1, [0] player 2
        logic [2*MOVE_W-1:0] offset;
    } setup_u;

endpackage

//--- design/morra_top.sv
`timescale 1ns/1ps

module morra_top import morra_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    play,
    input  move_t   move_1,
    input  move_t   move_2,
    output result_t round_result,
    output result_t game_result
);

    setup_u  setup;
    logic    round_valid;
    result_t round_winner;
    logic    min_reached;
    logic    limit_reached;

    // Player 1 in the upper half, also the limit offset on start
    assign setup = {move_1, move_2};

    round_referee u_referee (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .play         (play),
        .setup        (setup),
        .round_valid  (round_valid),
        .round_winner (round_winner)
    );

    round_counter u_counter (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .play          (play),
        .round_valid   (round_valid),
        .setup         (setup),
        .min_reached   (min_reached),
        .limit_reached (limit_reached)
    );

    score_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .play          (play),
        .round_valid   (round_valid),
        .min_reached   (min_reached),
        .limit_reached (limit_reached),
        .round_winner  (round_winner),
        .round_result  (round_result),
        .game_result   (game_result)
    );

endmodule

//--- design/round_counter.sv
`timescale 1ns/1ps

module round_counter import morra_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   play,
    input  logic   round_valid,
    input  setup_u setup,
    output logic   min_reached,
    output logic   limit_reached
);

    logic [COUNT_W-1:0] count;        // Valid rounds played so far
    logic [COUNT_W-1:0] limit;
    logic [COUNT_W-1:0] count_next;   // Count including the current round

    assign count_next = count + COUNT_W'(1);

    // Flags look one round ahead so the FSM can end the game on this play
    assign min_reached   = count_next >= MIN_ROUNDS;
    assign limit_reached = count_next >= limit;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            limit <= MIN_ROUNDS;
        end else if (start) begin
            count <= '0;
            limit <= MIN_ROUNDS + COUNT_W'(setup.offset);   // 4 to 19 rounds
        end else if (play && round_valid && count < limit) begin
            // Holds at the limit while idle after a game
            count <= count_next;
        end
    end

    count_within_limit: assert property (
        @(posedge clk) disable iff (rst)
        count <= limit
    );

endmodule

//--- design/round_referee.sv
`timescale 1ns/1ps

module round_referee import morra_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    play,
    input  setup_u  setup,
    output logic    round_valid,
    output result_t round_winner
);

    move_t   p1_move;
    move_t   p2_move;
    result_t judged;        // Winner of the bare move pair
    logic    repeat_move;
    logic    take;

    // Memory for the repeat rule
    result_t prev_winner;   // RES_NONE after a draw or at game start
    move_t   prev_move;     // Move the previous winner won with

    assign p1_move = setup.moves[1];
    assign p2_move = setup.moves[0];

    // Paper > rock, rock > scissors, scissors > paper
    always_comb begin
        if (p1_move == p2_move) begin
            judged = RES_DRAW;
        end else if ((p1_move == MOVE_PAPER && p2_move == MOVE_ROCK) ||
                     (p1_move == MOVE_ROCK && p2_move == MOVE_SCISSORS) ||
                     (p1_move == MOVE_SCISSORS && p2_move == MOVE_PAPER)) begin
            judged = RES_P1;
        end else begin
            judged = RES_P2;
        end
    end

    // Previous winner may not reuse its winning move
    assign repeat_move = (prev_winner == RES_P1 && p1_move == prev_move) ||
                         (prev_winner == RES_P2 && p2_move == prev_move);

    assign round_valid  = (p1_move != MOVE_NONE) && (p2_move != MOVE_NONE) && !repeat_move;
    assign round_winner = round_valid ? judged : RES_NONE;

    assign take = play && round_valid && !start;

    always_ff @(posedge clk) begin
        if (rst || start) begin
            prev_winner <= RES_NONE;
        end else if (take) begin
            // A draw leaves nobody bound by the rule
            prev_winner <= (judged == RES_DRAW) ? RES_NONE : judged;
        end
    end

    // Winning move of the last counted round
    always_ff @(posedge clk) begin
        if (take) begin
            prev_move <= (judged == RES_P2) ? p2_move : p1_move;
        end
    end

    // A play with a missing move is not counted, so the memory stays put
    no_move_never_valid: assert property (
        @(posedge clk) disable iff (rst)
        (play && !start && (p1_move == MOVE_NONE || p2_move == MOVE_NONE))
            |=> (prev_winner == $past(prev_winner))
    );

endmodule

//--- design/score_fsm.sv
`timescale 1ns/1ps

module score_fsm import morra_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    play,
    input  logic    round_valid,
    input  logic    min_reached,
    input  logic    limit_reached,
    input  result_t round_winner,
    output result_t round_result,
    output result_t game_result
);

    // Idle plus seven lead states from -3 to +3
    logic    active;         // Low while idle
    lead_t   lead;
    lead_t   lead_next;
    lead_t   lead_abs;
    logic    game_over;
    result_t final_result;
    logic    scored;

    // A play only counts inside a game
    assign scored = play && active && round_valid;

    always_comb begin
        case (round_winner)
            RES_P1:  lead_next = lead + 3'sd1;
            RES_P2:  lead_next = lead - 3'sd1;
            default: lead_next = lead;    // Draw keeps the lead
        endcase
    end

    assign lead_abs = (lead_next < 3'sd0) ? -lead_next : lead_next;

    // End-of-game rules after this round
    assign game_over = (lead_abs == LEAD_WIN) ||
                       (lead_abs >= LEAD_EARLY && min_reached) ||
                       limit_reached;

    always_comb begin
        if (lead_next > 3'sd0) begin
            final_result = RES_P1;
        end else if (lead_next < 3'sd0) begin
            final_result = RES_P2;
        end else begin
            final_result = RES_DRAW;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active       <= 1'b0;
            lead         <= '0;
            round_result <= RES_NONE;
            game_result  <= RES_NONE;
        end else if (start) begin
            // Restart from any state, a play in this cycle is dropped
            active       <= 1'b1;
            lead         <= '0;
            round_result <= RES_NONE;
            game_result  <= RES_NONE;
        end else if (scored) begin
            round_result <= round_winner;
            if (game_over) begin
                active      <= 1'b0;
                lead        <= '0;
                game_result <= final_result;
            end else begin
                lead        <= lead_next;
                game_result <= RES_NONE;
            end
        end else begin
            // Results last a single cycle
            round_result <= RES_NONE;
            game_result  <= RES_NONE;
        end
    end

    game_has_round: assert property (
        @(posedge clk) disable iff (rst)
        (game_result != RES_NONE) |-> (round_result != RES_NONE)
    );

endmodule

//--- src.f
design/morra_pkg.sv
design/round_referee.sv
design/round_counter.sv
design/score_fsm.sv
design/morra_top.sv
testbench/tb_morra.sv

//--- testbench/morra_stimulus.txt
// Columns: valid_start_play_move1_move2_expround_expgame, one entry per clock cycle
// Expected results are the outputs after the edge that samples the entry
// Moves 00 none, 01 rock, 10 paper, 11 scissors

// Idle after reset
1_0_0_00_00_00_00
1_0_0_00_00_00_00
1_0_1_10_01_00_00   // Play before any start
1_0_0_00_00_00_00

// Game with offset 15, all nine move pairs
1_1_0_11_11_00_00
1_0_1_01_01_11_00   // Rock rock draw
1_0_1_10_10_11_00   // Paper paper draw
1_0_1_11_11_11_00   // Scissors draw
1_0_1_10_01_01_00   // Paper beats rock, lead +1
1_0_0_00_00_00_00   // Result gone again
1_0_1_01_10_10_00   // Lead 0
1_0_1_01_11_01_00   // Lead +1
1_0_1_11_01_10_00   // Lead 0
1_0_1_11_10_01_00   // Lead +1
1_0_1_10_11_10_00   // Lead 0, player 2 won with scissors
1_0_1_00_10_00_00   // No move from player 1
1_0_1_01_11_00_00   // Player 2 repeats scissors
1_0_1_01_10_10_00   // Lead -1
1_0_1_10_01_01_00   // Lead 0, player 1 won with paper
1_0_1_10_11_00_00   // Player 1 repeats paper
1_0_1_00_00_00_00
1_0_1_01_01_11_00   // Draw clears the repeat rule
1_0_1_10_01_01_00   // Lead +1
1_0_1_11_11_11_00
1_0_1_10_01_01_01   // Paper again is fine after a draw, lead +2 past round 4
1_0_1_01_11_00_00   // Idle after the game
1_0_0_00_00_00_00

// Lead of 3 for player 1, offset 5
1_1_0_01_01_00_00
1_0_1_10_01_01_00
1_0_1_01_11_01_00   // Lead +2 after two rounds goes on
1_0_1_11_10_01_01   // Lead +3
1_0_0_00_00_00_00

// Lead of 3 for player 2, offset 10
1_1_0_10_10_00_00
1_0_1_01_10_10_00
1_0_1_11_01_10_00
1_0_1_10_01_00_00   // Player 2 repeats rock
1_0_1_10_11_10_10   // Lead -3
1_0_0_00_00_00_00

// Restart in mid-game
1_1_0_00_00_00_00
1_0_1_10_01_01_00
1_0_1_01_11_01_00   // Lead +2, player 1 won with rock
1_1_1_01_10_00_00   // Start wins over play, offset 6
1_0_1_01_10_10_00   // Rock allowed again, lead -1
1_0_1_11_01_10_00
1_0_1_10_11_10_10   // Lead -3 only if the old score is gone
1_0_0_00_00_00_00

// Offset 0, alternating wins
1_1_0_00_00_00_00
1_0_1_10_01_01_00
1_0_1_01_10_10_00
1_0_1_01_11_01_00
1_0_1_11_01_10_11   // Round 4 is the limit, lead 0
1_0_1_10_01_00_00   // Idle after the game
1_0_0_00_00_00_00

// Offset 2 gives six rounds
1_1_0_00_10_00_00
1_0_1_10_01_01_00
1_0_1_01_10_10_00
1_0_1_01_11_01_00
1_0_1_11_01_10_00   // Round 4 does not end it
1_0_0_00_00_00_00
1_0_1_11_10_01_00
1_0_1_10_11_10_11   // Round 6, lead 0
1_0_1_01_11_00_00
1_0_0_00_00_00_00

//--- testbench/tb_morra.sv
`timescale 1ns/1ps

module tb_morra import morra_pkg::*; ();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 3;
    localparam int    DRIVE_DELAY  = 1;     // After the rising edge
    localparam int    MAX_ENTRIES  = 256;
    localparam int    WD_MARGIN    = 20;    // Spare cycles for the watchdog
    localparam string STIM_FILE    = "testbench/morra_stimulus.txt";

    logic    clk;
    logic    rst;
    logic    start;
    logic    play;
    move_t   move_1;
    move_t   move_2;
    result_t round_result;
    result_t game_result;

    // Valid, start, play, move_1, move_2, expected round, expected game
    logic [10:0] stim_mem [MAX_ENTRIES];

    int   n_entries;
    logic loaded;          // Set once the entry count is known
    int   round_errors;
    int   game_errors;
    int   setup_errors;

    morra_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .play         (play),
        .move_1       (move_1),
        .move_2       (move_2),
        .round_result (round_result),
        .game_result  (game_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic drive_idle();
        start  = 1'b0;
        play   = 1'b0;
        move_1 = MOVE_NONE;
        move_2 = MOVE_NONE;
    endtask

    task automatic apply_entry(input int idx);
        logic [10:0] entry;
        entry  = stim_mem[idx];
        start  = entry[9];
        play   = entry[8];
        move_1 = entry[7:6];
        move_2 = entry[5:4];
    endtask

    // Outputs seen after the edge that sampled entry idx
    task automatic check_entry(input int idx);
        result_t exp_round;
        result_t exp_game;
        exp_round = stim_mem[idx][3:2];
        exp_game  = stim_mem[idx][1:0];
        assert (round_result == exp_round) else begin
            round_errors++;
            $display("CHECK FAILED at %0t: entry %0d round_result %b, expected %b",
                     $time, idx, round_result, exp_round);
        end
        assert (game_result == exp_game) else begin
            game_errors++;
            $display("CHECK FAILED at %0t: entry %0d game_result %b, expected %b",
                     $time, idx, game_result, exp_game);
        end
    endtask

    task automatic load_stimulus();
        // Unused entries keep the valid column low
        for (int a = 0; a < MAX_ENTRIES; a++) begin
            stim_mem[a] = {3'b000, 8'(a)};
        end
        $readmemb(STIM_FILE, stim_mem);
        n_entries = 0;
        while (n_entries < MAX_ENTRIES && stim_mem[n_entries][10]) begin
            n_entries++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        loaded       = 1'b0;
        round_errors = 0;
        game_errors  = 0;
        setup_errors = 0;
        drive_idle();

        load_stimulus();
        loaded = 1'b1;
        if (n_entries == 0) begin
            setup_errors++;
            $display("No stimulus entries could be read from %s", STIM_FILE);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        if (n_entries > 0) begin
            apply_entry(0);
        end

        // Check the previous entry, then drive the next one
        for (int i = 1; i <= n_entries; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_entry(i - 1);
            if (i < n_entries) begin
                apply_entry(i);
            end else begin
                drive_idle();
            end
        end

        $display("Entries: %0d, errors: %0d round result, %0d game result, %0d setup",
                 n_entries, round_errors, game_errors, setup_errors);
        if (round_errors + game_errors + setup_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (loaded);
        #((n_entries + WD_MARGIN) * CLK_PERIOD);
        $display("Watchdog timeout: the run did not end within %0d clock cycles",
                 n_entries + WD_MARGIN);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
